//--- vlog.f
+incdir+common
common/jpeg_out_pkg.sv
hdl/frame_controller.sv
hdl/bit_packer.sv
byte_stream/byte_serializer.sv
byte_stream/byte_stuffer.sv
hdl/jpeg_entropy_output.sv
bench/jpeg_out_sva.sv
bench/tb_jpeg_entropy_output.sv

//--- run_sim.sh
#!/bin/sh
# build and run the jpeg entropy output testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f --top-module tb_jpeg_entropy_output -Mdir obj_dir \
    && ./obj_dir/Vtb_jpeg_entropy_output | tee /dev/stderr | grep -qF '** PASS **' \
    || { echo "simulation did not pass"; exit 1; }

echo "simulation passed"

//--- bench/tb_jpeg_entropy_output.sv
/*
 * testbench for the jpeg entropy output back end
 * directed tests checked against a bit-level model of packing and stuffing
 */

`timescale 1ns/100ps
`include "jpeg_out_params.svh"

module tb_jpeg_entropy_output import jpeg_out_pkg::*; ();

    localparam int SETTLE_LIMIT    = 4000;
    localparam int WATCHDOG_CYCLES =
        5 * (`JO_MCUS_PER_FRAME * 4 + `JO_DRAIN_CYCLES + 2000);

    logic                  clock;
    logic                  nreset;
    logic                  frame_start_i;
    logic                  mcu_done_i;
    logic                  code_valid_i;
    logic [`JO_WORD_W-1:0] code_i;
    logic [`JO_LEN_W-1:0]  code_len_i;
    logic                  byte_valid_o;
    jo_byte_t              byte_o;
    logic                  vsync_o;

    jo_byte_t got_q[$];
    jo_byte_t exp_q[$];
    bit       model_bits[$];
    int       test_errs;
    int       pass_count;
    int       fail_count;

    jpeg_entropy_output u_dut (
        .clock         (clock),
        .nreset        (nreset),
        .frame_start_i (frame_start_i),
        .mcu_done_i    (mcu_done_i),
        .code_valid_i  (code_valid_i),
        .code_i        (code_i),
        .code_len_i    (code_len_i),
        .byte_valid_o  (byte_valid_o),
        .byte_o        (byte_o),
        .vsync_o       (vsync_o)
    );

    always #5 clock = ~clock;

    // collect the stuffed stream mid-cycle
    always @(negedge clock) begin
        if (byte_valid_o) begin
            got_q.push_back(byte_o);
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("simulation timed out after %0d cycles", WATCHDOG_CYCLES);
        $display("** FAIL **");
        $finish;
    end

    //////////////////////////////////////////////////
    // reporting and stimulus helpers

    task automatic flag_mismatch(input string msg);
        $display("FAIL %0t: %s", $time, msg);
        test_errs++;
    endtask

    task automatic flag_problem(input string msg);
        $display("%s", msg);
        test_errs++;
    endtask

    task automatic step(input int n);
        repeat (n) begin
            @(posedge clock);
            #1;
        end
    endtask

    task automatic apply_reset();
        nreset        = 1'b1;
        frame_start_i = 1'b0;
        mcu_done_i    = 1'b0;
        code_valid_i  = 1'b0;
        code_i        = '0;
        code_len_i    = '0;
        model_bits.delete();
        step(10);
        nreset = 1'b0;
    endtask

    task automatic drive_code(input logic [31:0] value, input int len);
        code_valid_i = 1'b1;
        code_i       = value;
        code_len_i   = `JO_LEN_W'(len);
        step(1);
        code_valid_i = 1'b0;
    endtask

    // append bits MSB-first and turn every full word into stuffed bytes
    task automatic model_append(input logic [31:0] value, input int len);
        jo_word_u w;
        for (int i = len - 1; i >= 0; i--) begin
            model_bits.push_back(value[i]);
        end
        while (model_bits.size() >= 32) begin
            for (int i = 0; i < 32; i++) begin
                w.bits = {w.bits[30:0], model_bits.pop_front()};
            end
            for (int b = 3; b >= 0; b--) begin
                exp_q.push_back(w.lanes[b]);
                if (w.lanes[b] == 8'hff) begin
                    exp_q.push_back(8'h00);
                end
            end
        end
    endtask

    task automatic send_code(input logic [31:0] value, input int len);
        drive_code(value, len);
        model_append(value, len);
    endtask

    task automatic pulse_frame_start();
        frame_start_i = 1'b1;
        step(1);
        frame_start_i = 1'b0;
    endtask

    // an idle cycle before each pulse, so the count lands just before return
    task automatic send_mcu_pulses(input int n);
        repeat (n) begin
            step(1);
            mcu_done_i = 1'b1;
            step(1);
            mcu_done_i = 1'b0;
        end
    endtask

    task automatic begin_test();
        got_q.delete();
        exp_q.delete();
        test_errs = 0;
    endtask

    task automatic wait_for_bytes(input string name);
        int waited;
        waited = 0;
        while (got_q.size() < exp_q.size() && waited < SETTLE_LIMIT) begin
            step(1);
            waited++;
        end
        if (got_q.size() < exp_q.size()) begin
            flag_problem($sformatf("%s: timed out waiting for output bytes", name));
        end
        // quiet period so that stray bytes show up
        step(16);
    endtask

    task automatic compare_bytes(input string name);
        int n;
        n = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
        if (got_q.size() != exp_q.size()) begin
            flag_mismatch($sformatf("%s: %0d bytes out, expected %0d",
                                    name, got_q.size(), exp_q.size()));
        end
        for (int i = 0; i < n; i++) begin
            if (got_q[i] !== exp_q[i]) begin
                flag_mismatch($sformatf("%s: byte %0d is %02h, expected %02h",
                                        name, i, got_q[i], exp_q[i]));
            end
        end
    endtask

    task automatic finish_test(input string name);
        if (test_errs == 0) begin
            pass_count++;
            $display("test %s passed", name);
        end else begin
            fail_count++;
            $display("test %s failed with %0d errors", name, test_errs);
        end
    endtask

    //////////////////////////////////////////////////
    // directed tests

    task automatic test_fixed_length();
        jo_byte_t code;
        begin_test();
        for (int i = 0; i < 32; i++) begin
            code = jo_byte_t'(i * 7 + 3);
            drive_code(32'(code), 8);
            exp_q.push_back(code);
        end
        wait_for_bytes("fixed_length");
        compare_bytes("fixed_length");
        foreach (got_q[i]) begin
            if (got_q[i] == 8'hff) begin
                flag_mismatch($sformatf("fixed_length: unexpected 0xff at byte %0d", i));
            end
        end
        finish_test("fixed_length");
    endtask

    task automatic test_mixed_lengths();
        int          len;
        logic [31:0] value;
        begin_test();
        for (int i = 0; i < 100; i++) begin
            len   = 1 + int'($urandom % 24);
            value = $urandom;
            send_code(value, len);
            // roughly 4 code bits per cycle
            step((len + 3) / 4 - 1);
        end
        // fill up to a word boundary so the next test starts aligned
        if (model_bits.size() != 0) begin
            send_code($urandom, 32 - model_bits.size());
        end
        wait_for_bytes("mixed_lengths");
        compare_bytes("mixed_lengths");
        finish_test("mixed_lengths");
    endtask

    task automatic test_byte_stuffing();
        jo_byte_t stuffed[7] = '{8'hff, 8'h00, 8'h12, 8'hff, 8'h00, 8'hff, 8'h00};
        begin_test();
        drive_code(32'h0000ff12, 16);
        drive_code(32'h0000ffff, 16);
        foreach (stuffed[i]) begin
            exp_q.push_back(stuffed[i]);
        end
        wait_for_bytes("byte_stuffing");
        compare_bytes("byte_stuffing");
        finish_test("byte_stuffing");
    endtask

    task automatic test_frame_flush();
        begin_test();
        pulse_frame_start();
        send_code(32'h000abcde, 20);
        send_mcu_pulses(`JO_MCUS_PER_FRAME);
        // flush pads with ones and the ones past the word are cleared
        model_append(32'hffffffff, 32);
        model_bits.delete();
        // late codes start in the first cycle of the finished frame
        for (int i = 0; i < 4; i++) begin
            drive_code(32'h00000055, 8);
        end
        wait_for_bytes("frame_flush");
        pulse_frame_start();
        send_code(32'h00001234, 16);
        send_code(32'h00005678, 16);
        wait_for_bytes("frame_flush");
        compare_bytes("frame_flush");
        finish_test("frame_flush");
    endtask

    task automatic test_vsync_framing();
        int waited;
        int seen;
        begin_test();
        apply_reset();
        pulse_frame_start();
        for (int i = 0; i < 5; i++) begin
            if (vsync_o !== 1'b0) begin
                flag_mismatch("vsync_framing: vsync high before the first word");
            end
            step(1);
        end
        drive_code(32'h0a1b2c3d, 32);
        seen   = 0;
        waited = 0;
        while (seen < 4 && waited < 50) begin
            @(negedge clock);
            if (byte_valid_o) begin
                seen++;
                if (vsync_o !== 1'b1) begin
                    flag_mismatch("vsync_framing: vsync low while a byte is emitted");
                end
            end
            waited++;
        end
        if (seen < 4) begin
            flag_problem("vsync_framing: timed out waiting for the first word's bytes");
        end
        step(1);
        send_mcu_pulses(`JO_MCUS_PER_FRAME);
        waited = 0;
        while (vsync_o && waited < `JO_DRAIN_CYCLES + 10) begin
            step(1);
            waited++;
        end
        if (vsync_o !== 1'b0) begin
            flag_mismatch("vsync_framing: vsync still high after the drain time");
        end
        pulse_frame_start();
        for (int i = 0; i < 20; i++) begin
            if (vsync_o !== 1'b0) begin
                flag_mismatch("vsync_framing: vsync rose before the next frame's word");
            end
            step(1);
        end
        drive_code(32'h01020304, 32);
        waited = 0;
        while (!vsync_o && waited < 10) begin
            step(1);
            waited++;
        end
        if (vsync_o !== 1'b1) begin
            flag_problem("vsync_framing: vsync never rose for the next frame");
        end
        finish_test("vsync_framing");
    endtask

    initial begin
        clock      = 1'b0;
        pass_count = 0;
        fail_count = 0;
        test_errs  = 0;
        void'($urandom(32'h5df4));
        apply_reset();
        test_fixed_length();
        test_mixed_lengths();
        test_byte_stuffing();
        test_frame_flush();
        test_vsync_framing();
        $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- bench/jpeg_out_sva.sv
/*
 * jpeg entropy output assertions
 * serializer overflow, 0xFF stuffing and output state in reset
 */

`timescale 1ns/100ps

module jpeg_out_sva import jpeg_out_pkg::*; (
    input logic     clock,
    input logic     nreset,
    input logic     word_valid_i,
    input logic     fifo_full_i,
    input logic     byte_valid_i,
    input jo_byte_t byte_i
);

    // a word that meets a full FIFO is lost
    a_no_overflow: assert property (@(posedge clock) disable iff (nreset)
        word_valid_i |-> !fifo_full_i)
        else $error("packed word arrived while the serializer FIFO was full");

    // the stuffed zero follows right behind each 0xFF
    a_stuff_zero: assert property (@(posedge clock) disable iff (nreset)
        (byte_valid_i && byte_i == 8'hff) |=> (byte_valid_i && byte_i == 8'h00))
        else $error("0xFF output byte not followed by 0x00");

    a_quiet_in_reset: assert property (@(posedge clock)
        nreset |=> !byte_valid_i)
        else $error("byte_valid_o high during reset");

endmodule

bind jpeg_entropy_output jpeg_out_sva u_sva (
    .clock        (clock),
    .nreset       (nreset),
    .word_valid_i (word_valid),
    .fifo_full_i  (u_ser.fifo_full),
    .byte_valid_i (byte_valid_o),
    .byte_i       (byte_o)
);

//--- hdl/jpeg_entropy_output.sv
/*
 * jpeg entropy output back end
 * packs huffman codes into words, serializes them to bytes,
 * stuffs 0x00 after each 0xFF and frames the stream with vsync
 */

`timescale 1ns/100ps
`include "jpeg_out_params.svh"

module jpeg_entropy_output import jpeg_out_pkg::*; (
    input  logic                  clock,
    input  logic                  nreset,
    input  logic                  frame_start_i,
    input  logic                  mcu_done_i,
    input  logic                  code_valid_i,
    input  logic [`JO_WORD_W-1:0] code_i,
    input  logic [`JO_LEN_W-1:0]  code_len_i,
    output logic                  byte_valid_o,
    output jo_byte_t              byte_o,
    output logic                  vsync_o
);

    // controller to packer
    logic                  pk_valid;
    logic [`JO_WORD_W-1:0] pk_code;
    logic [`JO_LEN_W-1:0]  pk_len;
    logic                  pk_clear;

    // packer to serializer
    logic                  word_valid;
    jo_word_u              word;

    // serializer to stuffer
    logic                  ser_valid;
    jo_byte_t              ser_byte;
    logic                  stuf_ready;

    frame_controller u_ctrl (
        .clock         (clock),
        .nreset        (nreset),
        .frame_start_i (frame_start_i),
        .mcu_done_i    (mcu_done_i),
        .code_valid_i  (code_valid_i),
        .code_i        (code_i),
        .code_len_i    (code_len_i),
        .word_valid_i  (word_valid),
        .pk_valid_o    (pk_valid),
        .pk_code_o     (pk_code),
        .pk_len_o      (pk_len),
        .pk_clear_o    (pk_clear),
        .vsync_o       (vsync_o)
    );

    bit_packer u_packer (
        .clock         (clock),
        .nreset        (nreset),
        .pk_valid_i    (pk_valid),
        .pk_code_i     (pk_code),
        .pk_len_i      (pk_len),
        .pk_clear_i    (pk_clear),
        .word_valid_o  (word_valid),
        .word_o        (word)
    );

    byte_serializer u_ser (
        .clock         (clock),
        .nreset        (nreset),
        .word_valid_i  (word_valid),
        .word_i        (word),
        .ready_i       (stuf_ready),
        .byte_valid_o  (ser_valid),
        .byte_o        (ser_byte)
    );

    byte_stuffer u_stuf (
        .clock         (clock),
        .nreset        (nreset),
        .byte_valid_i  (ser_valid),
        .byte_i        (ser_byte),
        .ready_o       (stuf_ready),
        .byte_valid_o  (byte_valid_o),
        .byte_o        (byte_o)
    );

endmodule

//--- byte_stream/byte_stuffer.sv
/*
 * byte stuffer
 * registers each accepted byte and inserts 0x00 after every 0xFF
 */

`timescale 1ns/100ps

module byte_stuffer import jpeg_out_pkg::*; (
    input  logic     clock,
    input  logic     nreset,
    input  logic     byte_valid_i,
    input  jo_byte_t byte_i,
    output logic     ready_o,
    output logic     byte_valid_o,
    output jo_byte_t byte_o
);

    logic pending_q;
    logic accept;

    // hold off the serializer while the stuffed zero goes out
    assign ready_o = !pending_q;
    assign accept  = byte_valid_i && ready_o;

    always_ff @(posedge clock) begin
        if (nreset) begin
            pending_q    <= 1'b0;
            byte_valid_o <= 1'b0;
        end else begin
            byte_valid_o <= accept || pending_q;
            if (accept) begin
                pending_q <= (byte_i == 8'hff);
            end else begin
                pending_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            byte_o <= byte_i;
        end else if (pending_q) begin
            byte_o <= 8'h00;
        end
    end

endmodule

//--- byte_stream/byte_serializer.sv
/*
 * byte serializer
 * buffers packed words and sends each one as four bytes,
 * most significant lane first, under the stuffer's ready
 */

`timescale 1ns/100ps
`include "jpeg_out_params.svh"

module byte_serializer import jpeg_out_pkg::*; (
    input  logic     clock,
    input  logic     nreset,
    input  logic     word_valid_i,
    input  jo_word_u word_i,
    input  logic     ready_i,
    output logic     byte_valid_o,
    output jo_byte_t byte_o
);

    localparam int PTR_W = $clog2(`JO_FIFO_DEPTH);
    localparam int CNT_W = $clog2(`JO_FIFO_DEPTH + 1);

    localparam logic [CNT_W-1:0] DEPTH    = `JO_FIFO_DEPTH;
    localparam logic [1:0]       TOP_LANE = 2'(`JO_WORD_W / 8 - 1);

    jo_word_u         fifo_mem [`JO_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic [1:0]       lane_q;
    logic             fifo_full;
    logic             push;
    logic             pop;
    logic             byte_taken;

    // a word arriving on a full FIFO is dropped
    assign fifo_full    = (count_q == DEPTH);
    assign push         = word_valid_i && !fifo_full;
    assign byte_valid_o = (count_q != '0);
    assign byte_taken   = byte_valid_o && ready_i;
    assign pop          = byte_taken && (lane_q == 2'd0);
    assign byte_o       = fifo_mem[rd_ptr_q].lanes[lane_q];

    always_ff @(posedge clock) begin
        if (push) begin
            fifo_mem[wr_ptr_q] <= word_i;
        end
    end

    always_ff @(posedge clock) begin
        if (nreset) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            lane_q   <= TOP_LANE;
        end else begin
            // pointers wrap on their own since depth is a power of two
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end

            // walk lanes 3..0 of the head word
            if (byte_taken) begin
                lane_q <= (lane_q == 2'd0) ? TOP_LANE : lane_q - 1'b1;
            end
        end
    end

endmodule

//--- hdl/bit_packer.sv
/*
 * bit packer
 * appends the low pk_len_i bits of each code MSB-first and
 * emits a 32-bit word as soon as one is full
 */

`timescale 1ns/100ps
`include "jpeg_out_params.svh"

module bit_packer import jpeg_out_pkg::*; (
    input  logic                  clock,
    input  logic                  nreset,
    input  logic                  pk_valid_i,
    input  logic [`JO_WORD_W-1:0] pk_code_i,
    input  logic [`JO_LEN_W-1:0]  pk_len_i,
    input  logic                  pk_clear_i,
    output logic                  word_valid_o,
    output jo_word_u              word_o
);

    localparam logic [`JO_LEN_W:0] WORD_BITS = `JO_WORD_W;
    localparam logic [`JO_LEN_W:0] TWO_WORDS = 2 * `JO_WORD_W;

    // partial bits sit left-aligned with zeros below fill_q
    logic [`JO_WORD_W-1:0]   acc_q;
    logic [`JO_LEN_W-1:0]    fill_q;

    logic [`JO_WORD_W-1:0]   code_masked;
    logic [`JO_LEN_W:0]      fill_sum;
    logic [`JO_LEN_W:0]      fill_rem;
    logic [`JO_LEN_W:0]      shamt;
    logic [2*`JO_WORD_W-1:0] merged;
    logic                    word_full;

    always_comb begin
        code_masked = pk_code_i & ~({`JO_WORD_W{1'b1}} << pk_len_i);
        fill_sum    = {1'b0, fill_q} + {1'b0, pk_len_i};
        fill_rem    = fill_sum - WORD_BITS;
        // place the code's top bit just below the bits already held
        shamt       = TWO_WORDS - fill_sum;
        merged      = {acc_q, {`JO_WORD_W{1'b0}}} |
                      ({{`JO_WORD_W{1'b0}}, code_masked} << shamt);
        word_full   = (fill_sum >= WORD_BITS);
    end

    always_ff @(posedge clock) begin
        if (nreset) begin
            acc_q        <= '0;
            fill_q       <= '0;
            word_valid_o <= 1'b0;
        end else if (pk_clear_i) begin
            acc_q        <= '0;
            fill_q       <= '0;
            word_valid_o <= 1'b0;
        end else if (pk_valid_i && word_full) begin
            // low half is the carry into the next word
            acc_q        <= merged[`JO_WORD_W-1:0];
            fill_q       <= fill_rem[`JO_LEN_W-1:0];
            word_valid_o <= 1'b1;
        end else if (pk_valid_i) begin
            acc_q        <= merged[2*`JO_WORD_W-1:`JO_WORD_W];
            fill_q       <= fill_sum[`JO_LEN_W-1:0];
            word_valid_o <= 1'b0;
        end else begin
            word_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (pk_valid_i && word_full) begin
            word_o.bits <= merged[2*`JO_WORD_W-1:`JO_WORD_W];
        end
    end

endmodule

//--- hdl/frame_controller.sv
/*
 * frame controller
 * counts MCUs per frame, gates codes once the frame is done,
 * flushes the packer with one bits and drives vsync
 */

`timescale 1ns/100ps
`include "jpeg_out_params.svh"

module frame_controller (
    input  logic                  clock,
    input  logic                  nreset,
    input  logic                  frame_start_i,
    input  logic                  mcu_done_i,
    input  logic                  code_valid_i,
    input  logic [`JO_WORD_W-1:0] code_i,
    input  logic [`JO_LEN_W-1:0]  code_len_i,
    input  logic                  word_valid_i,
    output logic                  pk_valid_o,
    output logic [`JO_WORD_W-1:0] pk_code_o,
    output logic [`JO_LEN_W-1:0]  pk_len_o,
    output logic                  pk_clear_o,
    output logic                  vsync_o
);

    localparam int DRAIN_W = $clog2(`JO_DRAIN_CYCLES + 1);

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_FLUSH = 2'd1;
    localparam logic [1:0] ST_CLEAR = 2'd2;

    localparam logic [`JO_MCU_CNT_W-1:0] MCU_LIMIT   = `JO_MCUS_PER_FRAME;
    localparam logic [DRAIN_W-1:0]       DRAIN_LIMIT = `JO_DRAIN_CYCLES;
    localparam logic [`JO_LEN_W-1:0]     FULL_LEN    = `JO_WORD_W;

    logic [`JO_MCU_CNT_W-1:0] mcu_cnt_q;
    logic                     frame_done;
    logic [1:0]               state_q;
    logic [1:0]               state_d;
    logic [DRAIN_W-1:0]       drain_cnt_q;

    assign frame_done = (mcu_cnt_q >= MCU_LIMIT);

    //////////////////////////////////////////////////
    // flush sequence

    always_comb begin
        pk_valid_o = 1'b0;
        pk_code_o  = '0;
        pk_len_o   = '0;
        pk_clear_o = 1'b0;
        state_d    = state_q;
        case (state_q)
            ST_IDLE: begin
                // pass codes through until the frame is complete
                pk_valid_o = code_valid_i && !frame_done;
                pk_code_o  = code_i;
                pk_len_o   = code_len_i;
                if (frame_done) begin
                    state_d = ST_FLUSH;
                end
            end
            ST_FLUSH: begin
                // a full word of ones always completes the partial word
                pk_valid_o = 1'b1;
                pk_code_o  = '1;
                pk_len_o   = FULL_LEN;
                state_d    = ST_CLEAR;
            end
            ST_CLEAR: begin
                pk_clear_o = 1'b1;
                if (frame_start_i) begin
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (nreset) begin
            state_q   <= ST_IDLE;
            mcu_cnt_q <= '0;
        end else begin
            state_q <= state_d;
            if (frame_start_i) begin
                mcu_cnt_q <= '0;
            end else if (mcu_done_i && !frame_done) begin
                mcu_cnt_q <= mcu_cnt_q + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // vsync framing

    always_ff @(posedge clock) begin
        if (nreset) begin
            drain_cnt_q <= '0;
            vsync_o     <= 1'b0;
        end else begin
            // restart the drain time on every new word
            if (!frame_done || word_valid_i) begin
                drain_cnt_q <= '0;
            end else if (drain_cnt_q < DRAIN_LIMIT) begin
                drain_cnt_q <= drain_cnt_q + 1'b1;
            end

            if (word_valid_i) begin
                vsync_o <= 1'b1;
            end else if (drain_cnt_q >= DRAIN_LIMIT) begin
                vsync_o <= 1'b0;
            end
        end
    end

endmodule

//--- common/jpeg_out_pkg.sv
/*
 * jpeg entropy output types
 * byte type and the packed word seen either as bits or as byte lanes
 */

`include "jpeg_out_params.svh"

package jpeg_out_pkg;

    typedef logic [7:0] jo_byte_t;

    // one packed output word
    // bits is filled MSB-first by the packer
    // lanes[3] is the first byte on the stream
    typedef union packed {
        logic [`JO_WORD_W-1:0]           bits;
        jo_byte_t [`JO_WORD_W/8-1:0]     lanes;
    } jo_word_u;

endpackage

//--- common/jpeg_out_params.svh
/*
 * jpeg entropy output back end
 * widths, frame size, vsync drain time and serializer FIFO depth
 */

`ifndef JPEG_OUT_PARAMS_SVH
`define JPEG_OUT_PARAMS_SVH

// packed word width in bits
`define JO_WORD_W 32

// code length field, holds 0 to 32
`define JO_LEN_W 6

// 320x240 image in 8x8 blocks
`define JO_MCUS_PER_FRAME 1200
`define JO_MCU_CNT_W 11

// cycles vsync stays up once the last MCU is done
`define JO_DRAIN_CYCLES 256

// serializer word FIFO depth must be a power of two
`define JO_FIFO_DEPTH 8

`endif
